//--- cpuArchPkg.sv
`default_nettype none

package cpuArchPkg;

    // register file geometry
    localparam int dataWidth = 32;
    localparam int regAddrWidth = 5;

    // a register value and a register number
    typedef logic [dataWidth-1:0] wordT;
    typedef logic [regAddrWidth-1:0] regAddrT;

    // r0 reads as zero, so a write to it never forwards
    localparam regAddrT zeroReg = regAddrT'(0);

endpackage

`default_nettype wire

//--- forwardPkg.sv
`default_nettype none

package forwardPkg;

    // producer slots, youngest first
    typedef enum logic [1:0] {
        srcIdEx,
        srcExMem,
        srcMemWb,
        srcWb
    } sourceIdxT;

    // decode sees every slot, including the ALU result still in ID/EX
    localparam int numDecodeSources = 4;

    // execute sees EX/MEM, MEM/WB and write-back
    localparam int numExeSources = 3;

    // first slot of the execute path, its array index 0
    localparam int exeSourceBase = int'(srcExMem);

endpackage

`default_nettype wire

//--- operandBypass.sv
`timescale 1ns/1ns
`default_nettype none

module operandBypass
    import cpuArchPkg::*;
#(
    parameter int numSources = 3
) (
    input  regAddrT                 regNum,
    input  wordT                    fallback,
    input  regAddrT                 srcDest [numSources],
    input  logic [numSources-1:0]   srcWrite,
    input  wordT                    srcValue [numSources],
    output wordT                    operand,
    output logic                    hit
);

    logic [numSources-1:0] match;

    // a producer counts only when it writes a real register
    genvar g;
    generate
        for (g = 0; g < numSources; g++) begin : gMatch
            assign match[g] = srcWrite[g]
                              && (srcDest[g] != zeroReg)
                              && (srcDest[g] == regNum);
        end
    endgenerate

    // walk from oldest to youngest so the youngest match is left standing
    always_comb begin
        operand = fallback;
        hit = 1'b0;
        for (int i = numSources - 1; i >= 0; i--) begin
            if (match[i]) begin
                operand = srcValue[i];
                hit = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- exeOperandStage.sv
`timescale 1ns/1ns
`default_nettype none

module exeOperandStage
    import cpuArchPkg::*;
    import forwardPkg::*;
(
    input  logic    CLOCK,
    input  logic    RESET,

    // operands read in decode, now in ID/EX
    input  regAddrT exRs,
    input  regAddrT exRt,
    input  wordT    exValueA,
    input  wordT    exValueB,
    input  logic    exUsesImm,
    input  logic    exIsLink,

    // producers
    input  regAddrT exMemDest,
    input  logic    exMemWrite,
    input  wordT    exMemValue,
    input  regAddrT memWbDest,
    input  logic    memWbWrite,
    input  wordT    memWbValue,
    input  regAddrT wbDest,
    input  logic    wbWrite,
    input  wordT    wbValue,

    output wordT    exOperandA,
    output wordT    exOperandB,
    output logic    exeForward
);

    regAddrT                  srcDest [numExeSources];
    logic [numExeSources-1:0] srcWrite;
    wordT                     srcValue [numExeSources];

    wordT bypassA;
    wordT bypassB;
    logic hitA;
    logic hitB;

    wordT nextA;
    wordT nextB;
    logic nextForward;

    // producer table in priority order, ID/EX slot not present here
    always_comb begin
        srcDest[srcExMem - exeSourceBase]  = exMemDest;
        srcWrite[srcExMem - exeSourceBase] = exMemWrite;
        srcValue[srcExMem - exeSourceBase] = exMemValue;
        srcDest[srcMemWb - exeSourceBase]  = memWbDest;
        srcWrite[srcMemWb - exeSourceBase] = memWbWrite;
        srcValue[srcMemWb - exeSourceBase] = memWbValue;
        srcDest[srcWb - exeSourceBase]     = wbDest;
        srcWrite[srcWb - exeSourceBase]    = wbWrite;
        srcValue[srcWb - exeSourceBase]    = wbValue;
    end

    operandBypass #(.numSources(numExeSources)) i_bypassA (
        .regNum   (exRs),
        .fallback (exValueA),
        .srcDest  (srcDest),
        .srcWrite (srcWrite),
        .srcValue (srcValue),
        .operand  (bypassA),
        .hit      (hitA)
    );

    operandBypass #(.numSources(numExeSources)) i_bypassB (
        .regNum   (exRt),
        .fallback (exValueB),
        .srcDest  (srcDest),
        .srcWrite (srcWrite),
        .srcValue (srcValue),
        .operand  (bypassB),
        .hit      (hitB)
    );

    // link keeps the return address in A, immediates keep their value in B
    assign nextA = exIsLink ? exValueA : bypassA;
    assign nextB = exUsesImm ? exValueB : bypassB;

    // flag only forwards that reached an operand
    assign nextForward = (hitA && !exIsLink) || (hitB && !exUsesImm);

    always_ff @(posedge CLOCK) begin
        if (!RESET) begin
            exOperandA <= '0;
            exOperandB <= '0;
            exeForward <= 1'b0;
        end else begin
            exOperandA <= nextA;
            exOperandB <= nextB;
            exeForward <= nextForward;
        end
    end

endmodule

`default_nettype wire

//--- decodeForward.sv
`timescale 1ns/1ns
`default_nettype none

module decodeForward
    import cpuArchPkg::*;
    import forwardPkg::*;
(
    // decode stage
    input  regAddrT idRs,
    input  regAddrT idRt,
    input  logic    isBranch,
    input  logic    isJumpReg,
    input  wordT    branchValueA,
    input  wordT    branchValueB,

    // producers, youngest first
    input  regAddrT idExDest,
    input  logic    idExWrite,
    input  wordT    aluResult,
    input  regAddrT exMemDest,
    input  logic    exMemWrite,
    input  logic    exMemRead,
    input  wordT    exMemValue,
    input  wordT    memReadData,
    input  regAddrT memWbDest,
    input  logic    memWbWrite,
    input  wordT    memWbValue,
    input  regAddrT wbDest,
    input  logic    wbWrite,
    input  wordT    wbValue,

    output wordT    branchOperandA,
    output wordT    branchOperandB,
    output logic    branchForward,
    output wordT    jumpTarget,
    output logic    jumpForward
);

    regAddrT                     srcDest [numDecodeSources];
    logic [numDecodeSources-1:0] srcWrite;
    wordT                        srcValue [numDecodeSources];

    logic hitRs;
    logic hitRt;
    logic hitJump;

    // a load in EX/MEM hands over the memory word instead of its address
    always_comb begin
        srcDest[srcIdEx]   = idExDest;
        srcWrite[srcIdEx]  = idExWrite;
        srcValue[srcIdEx]  = aluResult;
        srcDest[srcExMem]  = exMemDest;
        srcWrite[srcExMem] = exMemWrite;
        srcValue[srcExMem] = exMemRead ? memReadData : exMemValue;
        srcDest[srcMemWb]  = memWbDest;
        srcWrite[srcMemWb] = memWbWrite;
        srcValue[srcMemWb] = memWbValue;
        srcDest[srcWb]     = wbDest;
        srcWrite[srcWb]    = wbWrite;
        srcValue[srcWb]    = wbValue;
    end

    operandBypass #(.numSources(numDecodeSources)) i_bypassRs (
        .regNum   (idRs),
        .fallback (branchValueA),
        .srcDest  (srcDest),
        .srcWrite (srcWrite),
        .srcValue (srcValue),
        .operand  (branchOperandA),
        .hit      (hitRs)
    );

    operandBypass #(.numSources(numDecodeSources)) i_bypassRt (
        .regNum   (idRt),
        .fallback (branchValueB),
        .srcDest  (srcDest),
        .srcWrite (srcWrite),
        .srcValue (srcValue),
        .operand  (branchOperandB),
        .hit      (hitRt)
    );

    // jr target, kept apart from the branch compare path
    operandBypass #(.numSources(numDecodeSources)) i_bypassJump (
        .regNum   (idRs),
        .fallback (branchValueA),
        .srcDest  (srcDest),
        .srcWrite (srcWrite),
        .srcValue (srcValue),
        .operand  (jumpTarget),
        .hit      (hitJump)
    );

    assign branchForward = isBranch && (hitRs || hitRt);
    assign jumpForward = isJumpReg && hitJump;

endmodule

`default_nettype wire

//--- forwardUnit.sv
`timescale 1ns/1ns
`default_nettype none

module forwardUnit
    import cpuArchPkg::*;
(
    input  logic    CLOCK,
    input  logic    RESET,

    // decode
    input  regAddrT idRs,
    input  regAddrT idRt,
    input  logic    isBranch,
    input  logic    isJumpReg,
    input  wordT    branchValueA,
    input  wordT    branchValueB,

    // ID/EX
    input  regAddrT exRs,
    input  regAddrT exRt,
    input  wordT    exValueA,
    input  wordT    exValueB,
    input  logic    exUsesImm,
    input  logic    exIsLink,
    input  regAddrT idExDest,
    input  logic    idExWrite,
    input  wordT    aluResult,

    // EX/MEM
    input  regAddrT exMemDest,
    input  logic    exMemWrite,
    input  logic    exMemRead,
    input  wordT    exMemValue,
    input  wordT    memReadData,

    // MEM/WB
    input  regAddrT memWbDest,
    input  logic    memWbWrite,
    input  wordT    memWbValue,

    // register file write port
    input  regAddrT wbDest,
    input  logic    wbWrite,
    input  wordT    wbValue,

    // to execute, one cycle later
    output wordT    exOperandA,
    output wordT    exOperandB,
    output logic    exeForward,

    // to decode, same cycle
    output wordT    branchOperandA,
    output wordT    branchOperandB,
    output logic    branchForward,
    output wordT    jumpTarget,
    output logic    jumpForward
);

    exeOperandStage i_exeOperandStage (
        .CLOCK      (CLOCK),
        .RESET      (RESET),
        .exRs       (exRs),
        .exRt       (exRt),
        .exValueA   (exValueA),
        .exValueB   (exValueB),
        .exUsesImm  (exUsesImm),
        .exIsLink   (exIsLink),
        .exMemDest  (exMemDest),
        .exMemWrite (exMemWrite),
        .exMemValue (exMemValue),
        .memWbDest  (memWbDest),
        .memWbWrite (memWbWrite),
        .memWbValue (memWbValue),
        .wbDest     (wbDest),
        .wbWrite    (wbWrite),
        .wbValue    (wbValue),
        .exOperandA (exOperandA),
        .exOperandB (exOperandB),
        .exeForward (exeForward)
    );

    // branch and jr resolved in decode
    decodeForward i_decodeForward (
        .idRs           (idRs),
        .idRt           (idRt),
        .isBranch       (isBranch),
        .isJumpReg      (isJumpReg),
        .branchValueA   (branchValueA),
        .branchValueB   (branchValueB),
        .idExDest       (idExDest),
        .idExWrite      (idExWrite),
        .aluResult      (aluResult),
        .exMemDest      (exMemDest),
        .exMemWrite     (exMemWrite),
        .exMemRead      (exMemRead),
        .exMemValue     (exMemValue),
        .memReadData    (memReadData),
        .memWbDest      (memWbDest),
        .memWbWrite     (memWbWrite),
        .memWbValue     (memWbValue),
        .wbDest         (wbDest),
        .wbWrite        (wbWrite),
        .wbValue        (wbValue),
        .branchOperandA (branchOperandA),
        .branchOperandB (branchOperandB),
        .branchForward  (branchForward),
        .jumpTarget     (jumpTarget),
        .jumpForward    (jumpForward)
    );

endmodule

`default_nettype wire

//--- tbClock.sv
`timescale 1ns/1ns
`default_nettype none

module tbClock (
    output logic CLOCK,
    output logic RESET
);

    localparam int halfPeriod = 10;
    localparam int resetCycles = 5;

    initial begin
        CLOCK = 1'b0;
        forever #halfPeriod CLOCK = ~CLOCK;
    end

    // release on a falling edge, like every other DUT input
    initial begin
        RESET = 1'b0;
        repeat (resetCycles) @(posedge CLOCK);
        @(negedge CLOCK);
        RESET = 1'b1;
    end

endmodule

`default_nettype wire

//--- forwardUnitAssertions.sv
`timescale 1ns/1ns
`default_nettype none

module forwardUnitAssertions
    import cpuArchPkg::*;
(
    input logic    CLOCK,
    input logic    RESET,
    input logic    isBranch,
    input logic    isJumpReg,
    input logic    branchForward,
    input logic    jumpForward,
    input logic    exeForward,
    input regAddrT exRs,
    input regAddrT exRt,
    input regAddrT exMemDest,
    input logic    exMemWrite,
    input regAddrT memWbDest,
    input logic    memWbWrite,
    input regAddrT wbDest,
    input logic    wbWrite
);

    int failures = 0;
    logic exeMatch;

    function automatic logic writesReg(input logic write, input regAddrT dest,
                                       input regAddrT regNum);
        return write && (dest != zeroReg) && (dest == regNum);
    endfunction

    // any execute producer aimed at rs or rt, before link and immediate gating
    assign exeMatch = writesReg(exMemWrite, exMemDest, exRs)
                      || writesReg(memWbWrite, memWbDest, exRs)
                      || writesReg(wbWrite, wbDest, exRs)
                      || writesReg(exMemWrite, exMemDest, exRt)
                      || writesReg(memWbWrite, memWbDest, exRt)
                      || writesReg(wbWrite, wbDest, exRt);

    // decode flags only for the instruction that uses them
    branchFlagNeedsBranch: assert property (@(posedge CLOCK) branchForward |-> isBranch)
        else begin
            failures++;
            $error("branchForward is set while isBranch is low");
        end

    jumpFlagNeedsJump: assert property (@(posedge CLOCK) jumpForward |-> isJumpReg)
        else begin
            failures++;
            $error("jumpForward is set while isJumpReg is low");
        end

    // first edge out of reset loads the flag from that edge's producers
    exeQuietAfterReset: assert property (
        @(posedge CLOCK) $rose(RESET) && !exeMatch |=> !exeForward
    ) else begin
            failures++;
            $error("exeForward is set after the first edge out of reset without a match");
        end

endmodule

`default_nettype wire

//--- forwardUnitTb.sv
`timescale 1ns/1ns
`default_nettype none

module forwardUnitTb
    import cpuArchPkg::*;
;

    localparam int numCycles = 400;
    localparam int clockPeriod = 20;
    localparam int watchdogNs = (numCycles + 5 + 20) * clockPeriod;
    localparam logic [31:0] seed = 32'hf00a_4ba3;

    logic CLOCK, RESET;
    regAddrT idRs, idRt, exRs, exRt, idExDest, exMemDest, memWbDest, wbDest;
    logic isBranch, isJumpReg, exUsesImm, exIsLink;
    logic idExWrite, exMemWrite, exMemRead, memWbWrite, wbWrite;
    wordT branchValueA, branchValueB, exValueA, exValueB;
    wordT aluResult, exMemValue, memReadData, memWbValue, wbValue;
    wordT exOperandA, exOperandB, branchOperandA, branchOperandB, jumpTarget;
    logic exeForward, branchForward, jumpForward;

    // execute expectations, one cycle behind the inputs
    wordT expA;
    wordT expB;
    logic expForward;
    int exeErrors = 0;
    int decodeErrors = 0;

    tbClock clockGen (.CLOCK(CLOCK), .RESET(RESET));

    forwardUnit i_forwardUnit (.*);

    bind forwardUnit forwardUnitAssertions i_forwardUnitAssertions (
        .CLOCK         (CLOCK),
        .RESET         (RESET),
        .isBranch      (isBranch),
        .isJumpReg     (isJumpReg),
        .branchForward (branchForward),
        .jumpForward   (jumpForward),
        .exeForward    (exeForward),
        .exRs          (exRs),
        .exRt          (exRt),
        .exMemDest     (exMemDest),
        .exMemWrite    (exMemWrite),
        .memWbDest     (memWbDest),
        .memWbWrite    (memWbWrite),
        .wbDest        (wbDest),
        .wbWrite       (wbWrite)
    );

    function automatic regAddrT randomReg();
        // r0..r3 only, so matches and r0 writes are common
        return regAddrT'($urandom_range(0, 3));
    endfunction

    function automatic logic oneInFour();
        return ($urandom_range(0, 3) == 0);
    endfunction

    // producer slots 0..3 are ID/EX, EX/MEM, MEM/WB, write-back
    function automatic int youngestMatch(input regAddrT regNum, input int first);
        regAddrT dest [4];
        logic write [4];
        int found;
        dest = '{idExDest, exMemDest, memWbDest, wbDest};
        write = '{idExWrite, exMemWrite, memWbWrite, wbWrite};
        found = -1;
        for (int i = first; i < 4 && found < 0; i++) begin
            if (write[i] && dest[i] != zeroReg && dest[i] == regNum) begin
                found = i;
            end
        end
        return found;
    endfunction

    task automatic compareValue(input string what, input logic [31:0] got,
                                input logic [31:0] expected, input bit decodePath);
        assert (got === expected) else begin
            if (decodePath) begin
                decodeErrors++;
            end else begin
                exeErrors++;
            end
            $display("MISMATCH at %0t: %s got %h, expected %h", $time, what, got, expected);
        end
    endtask

    task automatic clearInputs();
        {idRs, idRt, exRs, exRt, idExDest, exMemDest, memWbDest, wbDest} = '0;
        {isBranch, isJumpReg, exUsesImm, exIsLink} = '0;
        {idExWrite, exMemWrite, exMemRead, memWbWrite, wbWrite} = '0;
        {branchValueA, branchValueB, exValueA, exValueB} = '0;
        {aluResult, exMemValue, memReadData, memWbValue, wbValue} = '0;
    endtask

    task automatic driveRandom();
        idRs = randomReg();
        idRt = randomReg();
        exRs = randomReg();
        exRt = randomReg();
        idExDest = randomReg();
        exMemDest = randomReg();
        memWbDest = randomReg();
        wbDest = randomReg();
        isBranch = $urandom_range(0, 1);
        isJumpReg = $urandom_range(0, 1);
        exUsesImm = oneInFour();
        exIsLink = oneInFour();
        // writes are more likely than not
        idExWrite = !oneInFour();
        exMemWrite = !oneInFour();
        exMemRead = $urandom_range(0, 1);
        memWbWrite = !oneInFour();
        wbWrite = !oneInFour();
        branchValueA = $urandom();
        branchValueB = $urandom();
        exValueA = $urandom();
        exValueB = $urandom();
        aluResult = $urandom();
        exMemValue = $urandom();
        memReadData = $urandom();
        memWbValue = $urandom();
        wbValue = $urandom();
    endtask

    // next execute outputs, from the inputs now on the pins
    task automatic modelExecute();
        wordT value [4];
        int idxA;
        int idxB;
        value = '{aluResult, exMemValue, memWbValue, wbValue};
        idxA = youngestMatch(exRs, 1);
        idxB = youngestMatch(exRt, 1);
        if (exIsLink || idxA < 0) begin
            expA = exValueA;
        end else begin
            expA = value[idxA];
        end
        if (exUsesImm || idxB < 0) begin
            expB = exValueB;
        end else begin
            expB = value[idxB];
        end
        expForward = (idxA >= 0 && !exIsLink) || (idxB >= 0 && !exUsesImm);
    endtask

    task automatic checkExecute();
        compareValue("exOperandA", exOperandA, expA, 1'b0);
        compareValue("exOperandB", exOperandB, expB, 1'b0);
        compareValue("exeForward", 32'(exeForward), 32'(expForward), 1'b0);
    endtask

    task automatic checkDecode();
        wordT value [4];
        wordT expBranchA;
        wordT expBranchB;
        int idxRs;
        int idxRt;
        // a load in EX/MEM supplies the memory word
        value = '{aluResult, exMemRead ? memReadData : exMemValue, memWbValue, wbValue};
        idxRs = youngestMatch(idRs, 0);
        idxRt = youngestMatch(idRt, 0);
        expBranchA = (idxRs < 0) ? branchValueA : value[idxRs];
        expBranchB = (idxRt < 0) ? branchValueB : value[idxRt];
        compareValue("branchOperandA", branchOperandA, expBranchA, 1'b1);
        compareValue("branchOperandB", branchOperandB, expBranchB, 1'b1);
        compareValue("branchForward", 32'(branchForward),
                     32'(isBranch && (idxRs >= 0 || idxRt >= 0)), 1'b1);
        compareValue("jumpTarget", jumpTarget, expBranchA, 1'b1);
        compareValue("jumpForward", 32'(jumpForward), 32'(isJumpReg && idxRs >= 0), 1'b1);
    endtask

    initial begin
        int assertFailures;
        void'($urandom(seed));
        clearInputs();
        @(posedge RESET);
        #5;
        // registered outputs come out of reset cleared
        expA = '0;
        expB = '0;
        expForward = 1'b0;
        checkExecute();
        for (int cycle = 0; cycle < numCycles; cycle++) begin
            @(negedge CLOCK);
            driveRandom();
            #5;
            // execute outputs still show last cycle's inputs
            checkExecute();
            checkDecode();
            modelExecute();
        end
        @(negedge CLOCK);
        #5;
        checkExecute();
        assertFailures = i_forwardUnit.i_forwardUnitAssertions.failures;
        $display("errors: execute %0d, decode %0d, assertions %0d",
                 exeErrors, decodeErrors, assertFailures);
        if (exeErrors + decodeErrors + assertFailures == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        #(watchdogNs);
        $display("ERROR: watchdog expired before the stimulus loop finished");
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
cpuArchPkg.sv
forwardPkg.sv
operandBypass.sv
exeOperandStage.sv
decodeForward.sv
forwardUnit.sv
tbClock.sv
forwardUnitAssertions.sv
forwardUnitTb.sv
